/* byte_sync.sv */
/*
 * sck to clk_sys crossing
 * two-stage sync of the byte toggle and frame level, strobe on toggle edge
 */
`timescale 1ns/1ps
`default_nettype none

module byte_sync (
	input  logic                    clk_sys,
	input  user_io_pkg::spi_byte_t  spi_byte_i,
	input  logic                    spi_toggle_i,
	input  logic                    frame_end_i,
	output user_io_pkg::sync_byte_t sync_o
);

	import user_io_pkg::*;

	// [1:0] are the synchronizer, [2] keeps the previous value
	logic [2:0] tog_q;
	logic [1:0] fend_q;
	logic       tog_edge;
	logic       strobe_q;
	spi_byte_t  data_q;

	assign tog_edge = tog_q[1] ^ tog_q[2];

	always_ff @(posedge clk_sys) begin
		tog_q    <= {tog_q[1:0], spi_toggle_i};
		fend_q   <= {fend_q[0], frame_end_i};
		strobe_q <= tog_edge;
		// spi byte is stable for a whole byte time after its toggle
		if (tog_edge) begin
			data_q <= spi_byte_i;
		end
	end

	assign sync_o = '{
		data:     data_q,
		strobe:   strobe_q,
		in_frame: ~fend_q[1]
	};

	// one toggle flip per byte gives single-cycle strobes
	a_strobe_single: assert property (
		@(posedge clk_sys) strobe_q |=> !strobe_q
	);

endmodule

`default_nettype wire

/* command_decoder.sv */
/*
 * frame byte numbering
 * latches the command byte and tags every payload byte with it
 */
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
	input  logic                    clk_sys,
	input  user_io_pkg::sync_byte_t sync_i,
	output user_io_pkg::cmd_byte_t  cmd_o
);

	import user_io_pkg::*;

	byte_idx_t idx_q;
	spi_byte_t cmd_q;
	cmd_byte_t out_q;

	always_ff @(posedge clk_sys) begin
		out_q.valid <= 1'b0;
		if (!sync_i.in_frame) begin
			// between frames, next byte is a command again
			idx_q <= '0;
		end else if (sync_i.strobe) begin
			// saturate so a long payload never looks like a command
			if (idx_q != 8'hff) begin
				idx_q <= idx_q + 8'd1;
			end
			if (idx_q == 8'd0) begin
				cmd_q <= sync_i.data;
			end else begin
				out_q.cmd   <= cmd_q;
				out_q.idx   <= idx_q;
				out_q.data  <= sync_i.data;
				out_q.valid <= 1'b1;
			end
		end
	end

	assign cmd_o = out_q;

	// only payload bytes come out
	a_valid_payload: assert property (
		@(posedge clk_sys) out_q.valid |-> (out_q.idx != 8'd0)
	);

endmodule

`default_nettype wire

/* key_decoder.sv */
/*
 * keyboard event decoder
 * folds e0/f0 prefixes into pressed/extended flags of the next scan code
 */
`timescale 1ns/1ps
`default_nettype none

`include "user_io_config.svh"

module key_decoder (
	input  logic                    clk_sys,
	input  user_io_pkg::cmd_byte_t  cmd_i,
	output user_io_pkg::key_event_t key_o,
	output logic                    key_strobe_o
);

	import user_io_pkg::*;

	kbd_state_e state_q;
	logic       pressed_q;
	logic       extended_q;
	logic       kbd_byte;
	logic       fresh;
	logic       cur_pressed;
	logic       cur_extended;
	key_event_t key_q;
	logic       key_strobe_q;

	assign kbd_byte = cmd_i.valid && (cmd_i.cmd == `CMD_KBD);

	// first payload byte or no prefix seen: start from a plain make code
	assign fresh        = (cmd_i.idx == 8'd1) || (state_q == KBD_IDLE);
	assign cur_pressed  = fresh ? 1'b1 : pressed_q;
	assign cur_extended = fresh ? 1'b0 : extended_q;

	always_ff @(posedge clk_sys) begin
		key_strobe_q <= 1'b0;
		if (kbd_byte) begin
			if (cmd_i.data == `KEY_EXT_PREFIX) begin
				extended_q <= 1'b1;
				pressed_q  <= cur_pressed;
				state_q    <= KBD_PREFIXED;
			end else if (cmd_i.data == `KEY_BREAK_PREFIX) begin
				extended_q <= cur_extended;
				pressed_q  <= 1'b0;
				state_q    <= KBD_PREFIXED;
			end else begin
				// scan code closes the event
				key_q <= '{
					pressed:  cur_pressed,
					extended: cur_extended,
					code:     cmd_i.data
				};
				key_strobe_q <= 1'b1;
				state_q      <= KBD_IDLE;
			end
		end
	end

	assign key_o        = key_q;
	assign key_strobe_o = key_strobe_q;

	// every strobe traces back to a keyboard payload byte
	a_strobe_source: assert property (
		@(posedge clk_sys) key_strobe_q |-> $past(kbd_byte)
	);

endmodule

`default_nettype wire

/* project.f */
+incdir+.
user_io_pkg.sv
spi_deserializer.sv
byte_sync.sv
command_decoder.sv
settings_registers.sv
key_decoder.sv
user_io_top.sv
tb_user_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the user i/o testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_user_io -o sim_user_io

# a fatal stop exits non-zero, the log decides the result
./obj_dir/sim_user_io > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

/* settings_registers.sv */
/*
 * held core settings
 * buttons/switches, digital joysticks and status from tagged payload bytes
 */
`timescale 1ns/1ps
`default_nettype none

`include "user_io_config.svh"

module settings_registers (
	input  logic                   clk_sys,
	input  user_io_pkg::cmd_byte_t cmd_i,
	output logic [1:0]             buttons_o,
	output logic [1:0]             switches_o,
	output logic                   scandoubler_disable_o,
	output logic                   ypbpr_o,
	output logic                   no_csync_o,
	output user_io_pkg::joy_bank_t joystick_o,
	output user_io_pkg::status_t   status_o
);

	import user_io_pkg::*;

	but_sw_t   but_sw_q;
	joy_bank_t joy_q;
	status_t   status_q;
	// stick number for the 0x60.. commands
	spi_byte_t joy_sel;
	// byte lane of the payload byte, idx 1 is lane 0
	logic [2:0] lane;

	assign joy_sel = cmd_i.cmd - `CMD_JOY_BASE;
	assign lane    = cmd_i.idx[2:0] - 3'd1;

	// written only by frames, so kept across ss
	always_ff @(posedge clk_sys) begin
		if (cmd_i.valid) begin
			case (cmd_i.cmd)
				`CMD_BUT_SW: begin
					but_sw_q <= cmd_i.data;
				end
				`CMD_STATUS8: begin
					// legacy 8 bit status clears the upper bytes
					if (cmd_i.idx == 8'd1) begin
						status_q <= {56'd0, cmd_i.data};
					end
				end
				`CMD_STATUS64: begin
					if (cmd_i.idx <= `STATUS_BYTES) begin
						status_q[{lane, 3'b000} +: 8] <= cmd_i.data;
					end
				end
				default: begin
					// joystick range, lsb first
					if (joy_sel < spi_byte_t'(`JOY_COUNT) && cmd_i.idx <= `JOY_BYTES) begin
						joy_q[joy_sel[2:0]][{lane[1:0], 3'b000} +: 8] <= cmd_i.data;
					end
				end
			endcase
		end
	end

	// bit map of the buttons/switches byte
	assign buttons_o             = but_sw_q[1:0];
	assign switches_o            = but_sw_q[3:2];
	assign scandoubler_disable_o = but_sw_q[4];
	assign ypbpr_o               = but_sw_q[5];
	assign no_csync_o            = but_sw_q[6];

	assign joystick_o = joy_q;
	assign status_o   = status_q;

endmodule

`default_nettype wire

/* spi_deserializer.sv */
/*
 * spi receiver, sck domain
 * assembles mosi bits into bytes and flags each one with a toggle
 */
`timescale 1ns/1ps
`default_nettype none

module spi_deserializer (
	input  logic                  spi_sck_i,
	input  logic                  SPI_SS_IO,
	input  logic                  spi_mosi_i,
	output user_io_pkg::spi_byte_t spi_byte_o,
	output logic                  spi_toggle_o,
	output logic                  frame_end_o
);

	import user_io_pkg::*;

	logic [2:0] bit_cnt_q;
	logic [6:0] sbuf_q;
	spi_byte_t  byte_q;
	logic       toggle_q;
	logic       frame_end_q;

	// ss high both ends the frame and holds the stage in reset
	always_ff @(posedge spi_sck_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt_q   <= 3'd0;
			sbuf_q      <= 7'd0;
			byte_q      <= '0;
			toggle_q    <= 1'b0;
			frame_end_q <= 1'b1;
		end else begin
			frame_end_q <= 1'b0;
			bit_cnt_q   <= bit_cnt_q + 3'd1;
			// msb first, first seven bits go to the shifter
			if (bit_cnt_q != 3'd7) begin
				sbuf_q <= {sbuf_q[5:0], spi_mosi_i};
			end else begin
				// 8th edge completes the byte
				byte_q   <= {sbuf_q, spi_mosi_i};
				toggle_q <= ~toggle_q;
			end
		end
	end

	assign spi_byte_o   = byte_q;
	assign spi_toggle_o = toggle_q;
	assign frame_end_o  = frame_end_q;

	// a byte can only complete while the frame is open
	a_no_wrap_in_reset: assert property (
		@(posedge spi_sck_i) (bit_cnt_q == 3'd7) |-> !SPI_SS_IO
	);

endmodule

`default_nettype wire

/* tb_user_io.sv */
/*
 * testbench for the user i/o spi command receiver
 * table of frames against a rule model of settings and key events
 */
`timescale 1ns/1ps
`default_nettype none

`include "user_io_config.svh"

module tb_user_io;

	import user_io_pkg::*;

	localparam int ROWS = 16;

	logic       clk_sys = 1'b0;
	logic       spi_ss;
	logic       spi_sck;
	logic       spi_mosi;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic       sd_disable;
	logic       ypbpr;
	logic       no_csync;
	joy_bank_t  joystick;
	status_t    status;
	key_event_t key;
	logic       key_strobe;
	but_sw_t    but_sw_got;

	// frame table, payload byte 1 sits in bits 7:0, cut > 0 stops the command after that many bits
	spi_byte_t   row_cmd [ROWS];
	int          row_len [ROWS];
	int          row_cut [ROWS];
	logic [71:0] row_pl [ROWS];
	int          row_nkeys [ROWS];
	key_event_t  row_key [ROWS];

	// expected settings, only known lanes are compared
	but_sw_t                exp_but_sw;
	joy_bank_t              exp_joy;
	status_t                exp_status;
	status_t                status_mask;
	logic                   but_known;
	logic [`JOY_COUNT-1:0]  joy_known;
	key_event_t             ev_q [$];
	int                     keys_expected;
	integer                 seed;

	user_io_top i_dut (
		.clk_sys               (clk_sys),
		.SPI_SS_IO             (spi_ss),
		.spi_sck_i             (spi_sck),
		.spi_mosi_i            (spi_mosi),
		.buttons_o             (buttons),
		.switches_o            (switches),
		.scandoubler_disable_o (sd_disable),
		.ypbpr_o               (ypbpr),
		.no_csync_o            (no_csync),
		.joystick_o            (joystick),
		.status_o              (status),
		.key_o                 (key),
		.key_strobe_o          (key_strobe)
	);

	always #50 clk_sys = ~clk_sys;

	// split outputs put back into byte order, bit 7 has no output
	assign but_sw_got = {1'b0, no_csync, ypbpr, sd_disable, switches, buttons};

	// strobe is one cycle wide, so the falling edge sees it once
	always @(negedge clk_sys) begin
		if (key_strobe === 1'b1) begin
			ev_q.push_back(key);
		end
	end

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_but_sw(input string name, input but_sw_t got, input but_sw_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_joy(input string name, input joy_t got, input joy_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_key(input string name, input key_event_t got, input key_event_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = pressed %b ext %b code %h, expected %b %b %h",
				$time, name, got.pressed, got.extended, got.code,
				exp.pressed, exp.extended, exp.code);
			stop_run();
		end
	endtask

	task automatic set_row(input int r, input spi_byte_t cmd, input int len, input int cut,
			input bit rnd, input logic [71:0] pl, input int nkeys, input key_event_t ev);
		logic [31:0] word;
		row_cmd[r]   = cmd;
		row_len[r]   = len;
		row_cut[r]   = cut;
		row_pl[r]    = pl;
		row_nkeys[r] = nkeys;
		row_key[r]   = ev;
		if (rnd) begin
			for (int k = 0; k < len; k++) begin
				word = $random(seed);
				row_pl[r][8*k +: 8] = word[7:0];
			end
		end
	endtask

	// msb first, each sck phase lasts 4 clk_sys cycles
	task automatic send_frame(input int r);
		logic [7:0] b;
		int         nbits;
		nbits = (row_cut[r] != 0) ? row_cut[r] : 8;
		@(negedge clk_sys);
		spi_ss = 1'b0;
		repeat (4) @(negedge clk_sys);
		for (int j = 0; j <= row_len[r]; j++) begin
			b = (j == 0) ? row_cmd[r] : row_pl[r][8*(j-1) +: 8];
			for (int i = 7; i > 7 - nbits; i--) begin
				spi_sck  = 1'b0;
				spi_mosi = b[i];
				repeat (4) @(negedge clk_sys);
				spi_sck = 1'b1;
				repeat (4) @(negedge clk_sys);
			end
		end
		spi_sck = 1'b0;
		repeat (4) @(negedge clk_sys);
		spi_ss = 1'b1;
		// idle gap between frames
		repeat (8) @(negedge clk_sys);
	endtask

	// payload rules per command code
	task automatic apply_model(input int r);
		spi_byte_t d;
		int        n;
		n = int'(row_cmd[r]) - int'(`CMD_JOY_BASE);
		for (int k = 1; k <= row_len[r]; k++) begin
			d = row_pl[r][8*(k-1) +: 8];
			if (row_cmd[r] == `CMD_BUT_SW && k == 1) begin
				exp_but_sw = d;
				but_known  = 1'b1;
			end else if (row_cmd[r] == `CMD_STATUS8 && k == 1) begin
				exp_status  = {56'd0, d};
				status_mask = '1;
			end else if (row_cmd[r] == `CMD_STATUS64 && k <= int'(`STATUS_BYTES)) begin
				exp_status[8*(k-1) +: 8]  = d;
				status_mask[8*(k-1) +: 8] = 8'hff;
			end else if (n >= 0 && n < `JOY_COUNT && k <= int'(`JOY_BYTES)) begin
				exp_joy[n][8*(k-1) +: 8] = d;
				joy_known[n]             = 1'b1;
			end
		end
	endtask

	function automatic bit settings_match();
		bit ok;
		ok = 1'b1;
		if (but_known && but_sw_got !== {1'b0, exp_but_sw[6:0]}) ok = 1'b0;
		for (int n = 0; n < `JOY_COUNT; n++) begin
			if (joy_known[n] && joystick[n] !== exp_joy[n]) ok = 1'b0;
		end
		if ((status & status_mask) !== (exp_status & status_mask)) ok = 1'b0;
		return ok;
	endfunction

	task automatic check_settings();
		int cycles;
		cycles = 0;
		while (!settings_match() && cycles < 8) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (but_known) check_but_sw("buttons/switches", but_sw_got, {1'b0, exp_but_sw[6:0]});
		for (int n = 0; n < `JOY_COUNT; n++) begin
			if (joy_known[n]) check_joy($sformatf("joystick_o[%0d]", n), joystick[n], exp_joy[n]);
		end
		check_status("status_o", status & status_mask, exp_status & status_mask);
	endtask

	task automatic wait_for_key();
		int cycles;
		cycles = 0;
		while (ev_q.size() < keys_expected) begin
			if (cycles == 8) begin
				$display("ERROR at %0t: no key strobe after a keyboard frame", $time);
				stop_run();
			end
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	initial begin
		seed          = 32'he0e7;
		spi_ss        = 1'b1;
		spi_sck       = 1'b0;
		spi_mosi      = 1'b0;
		keys_expected = 0;
		but_known     = 1'b0;
		joy_known     = '0;
		exp_but_sw    = '0;
		exp_joy       = '0;
		exp_status    = '0;
		status_mask   = '0;

		set_row(0, `CMD_BUT_SW, 1, 0, 1'b1, '0, 0, '0);
		for (int n = 0; n < `JOY_COUNT; n++) begin
			set_row(1 + n, `CMD_JOY_BASE + spi_byte_t'(n), 4, 0, 1'b1, '0, 0, '0);
		end
		// fifth byte of a joystick frame is ignored
		set_row(6, `CMD_JOY_BASE + 8'd2, 5, 0, 1'b1, '0, 0, '0);
		set_row(7, `CMD_STATUS64, 8, 0, 1'b1, '0, 0, '0);
		set_row(8, `CMD_STATUS8, 1, 0, 1'b1, '0, 0, '0);
		set_row(9, `CMD_KBD, 1, 0, 1'b0, 72'h1c, 1, {1'b1, 1'b0, 8'h1c});
		set_row(10, `CMD_KBD, 2, 0, 1'b0, 72'h75e0, 1, {1'b1, 1'b1, 8'h75});
		set_row(11, `CMD_KBD, 2, 0, 1'b0, 72'h1cf0, 1, {1'b0, 1'b0, 8'h1c});
		set_row(12, `CMD_KBD, 3, 0, 1'b0, 72'h75f0e0, 1, {1'b0, 1'b1, 8'h75});
		// unknown command, then a command cut after 5 bits
		set_row(13, 8'h7b, 4, 0, 1'b1, '0, 0, '0);
		set_row(14, `CMD_JOY_BASE + 8'd4, 0, 5, 1'b0, '0, 0, '0);
		set_row(15, `CMD_BUT_SW, 1, 0, 1'b1, '0, 0, '0);

		// ss doubles as reset, high for the first 3 cycles
		repeat (2) @(negedge clk_sys);
		for (int r = 0; r < ROWS; r++) begin
			send_frame(r);
			apply_model(r);
			check_settings();
			if (row_nkeys[r] != 0) begin
				keys_expected += row_nkeys[r];
				wait_for_key();
				check_key("key_o", ev_q[keys_expected-1], row_key[r]);
			end
			if (ev_q.size() != keys_expected) begin
				$display("ERROR at %0t: %0d key strobes seen, %0d expected after frame %0d",
					$time, ev_q.size(), keys_expected, r);
				stop_run();
			end
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* user_io_config.svh */
/*
 * user i/o command receiver constants
 * command codes, keyboard prefixes and payload lengths
 */
`ifndef USER_IO_CONFIG_SVH
`define USER_IO_CONFIG_SVH

// command codes sent as the first byte of a frame
`define CMD_BUT_SW       8'h01
`define CMD_KBD          8'h05
`define CMD_STATUS8      8'h15
`define CMD_STATUS64     8'h1e
// first of the joystick commands, one code per stick
`define CMD_JOY_BASE     8'h60

// ps/2 set 2 prefixes inside a keyboard payload
`define KEY_EXT_PREFIX   8'he0
`define KEY_BREAK_PREFIX 8'hf0

// number of digital joysticks
`define JOY_COUNT        5

// payload lengths in bytes
`define JOY_BYTES        8'd4
`define STATUS_BYTES     8'd8

`endif

/* user_io_pkg.sv */
/*
 * user i/o shared types
 * byte, index and settings vectors plus the structs between stages
 */
`default_nettype none

`include "user_io_config.svh"

package user_io_pkg;

	// one byte as shifted in on mosi
	typedef logic [7:0] spi_byte_t;
	// byte position inside a frame, 0 is the command
	typedef logic [7:0] byte_idx_t;
	typedef logic [31:0] joy_t;
	typedef joy_t [`JOY_COUNT-1:0] joy_bank_t;
	typedef logic [63:0] status_t;
	// raw buttons/switches byte before it is split up
	typedef logic [7:0] but_sw_t;

	// byte after the clock crossing
	typedef struct packed {
		spi_byte_t data;
		logic      strobe;
		logic      in_frame;
	} sync_byte_t;

	// payload byte tagged with its command and position
	typedef struct packed {
		spi_byte_t cmd;
		byte_idx_t idx;
		spi_byte_t data;
		logic      valid;
	} cmd_byte_t;

	typedef struct packed {
		logic      pressed;
		logic      extended;
		spi_byte_t code;
	} key_event_t;

	// idle means no prefix is pending
	typedef enum logic {
		KBD_IDLE,
		KBD_PREFIXED
	} kbd_state_e;

endpackage

`default_nettype wire

/* user_io_top.sv */
/*
 * user i/o spi command receiver
 * sck-domain deserializer feeding clk_sys decode of settings and keys
 */
`timescale 1ns/1ps
`default_nettype none

module user_io_top (
	input  logic                    clk_sys,
	input  logic                    SPI_SS_IO,
	input  logic                    spi_sck_i,
	input  logic                    spi_mosi_i,
	output logic [1:0]              buttons_o,
	output logic [1:0]              switches_o,
	output logic                    scandoubler_disable_o,
	output logic                    ypbpr_o,
	output logic                    no_csync_o,
	output user_io_pkg::joy_bank_t  joystick_o,
	output user_io_pkg::status_t    status_o,
	output user_io_pkg::key_event_t key_o,
	output logic                    key_strobe_o
);

	import user_io_pkg::*;

	// only these three cross from sck into clk_sys
	spi_byte_t  spi_byte;
	logic       spi_toggle;
	logic       frame_end;
	sync_byte_t sync_byte;
	cmd_byte_t  cmd_byte;

	spi_deserializer i_spi_deserializer (
		.spi_sck_i    (spi_sck_i),
		.SPI_SS_IO    (SPI_SS_IO),
		.spi_mosi_i   (spi_mosi_i),
		.spi_byte_o   (spi_byte),
		.spi_toggle_o (spi_toggle),
		.frame_end_o  (frame_end)
	);

	byte_sync i_byte_sync (
		.clk_sys      (clk_sys),
		.spi_byte_i   (spi_byte),
		.spi_toggle_i (spi_toggle),
		.frame_end_i  (frame_end),
		.sync_o       (sync_byte)
	);

	command_decoder i_command_decoder (
		.clk_sys (clk_sys),
		.sync_i  (sync_byte),
		.cmd_o   (cmd_byte)
	);

	// both sinks see every payload byte and pick their own commands
	settings_registers i_settings_registers (
		.clk_sys               (clk_sys),
		.cmd_i                 (cmd_byte),
		.buttons_o             (buttons_o),
		.switches_o            (switches_o),
		.scandoubler_disable_o (scandoubler_disable_o),
		.ypbpr_o               (ypbpr_o),
		.no_csync_o            (no_csync_o),
		.joystick_o            (joystick_o),
		.status_o              (status_o)
	);

	key_decoder i_key_decoder (
		.clk_sys      (clk_sys),
		.cmd_i        (cmd_byte),
		.key_o        (key_o),
		.key_strobe_o (key_strobe_o)
	);

endmodule

`default_nettype wire
